/* common/dzcpuPkg.sv */
package dzcpuPkg;

	localparam logic [7:0] opNop   = 8'h00;
	localparam logic [7:0] opLdBn  = 8'h06;
	localparam logic [7:0] opLdCn  = 8'h0E;
	localparam logic [7:0] opLdAn  = 8'h3E;
	localparam logic [7:0] opIncB  = 8'h04;
	localparam logic [7:0] opIncC  = 8'h0C;
	localparam logic [7:0] opIncA  = 8'h3C;
	localparam logic [7:0] opDecB  = 8'h05;
	localparam logic [7:0] opDecC  = 8'h0D;
	localparam logic [7:0] opDecA  = 8'h3D;
	localparam logic [7:0] opAddAB = 8'h80;
	localparam logic [7:0] opSubAB = 8'h90;
	localparam logic [7:0] opXorN  = 8'hEE;
	localparam logic [7:0] opJrNz  = 8'h20;
	localparam logic [7:0] opJpNn  = 8'hC3;
	localparam logic [7:0] opHalt  = 8'h76;

	localparam int uopIdxW = 9;
	localparam int regIdxW = 3;

	localparam logic [uopIdxW-1:0] flowNop    = 9'd0;
	localparam logic [uopIdxW-1:0] flowLdRn   = 9'd1;
	localparam logic [uopIdxW-1:0] flowIncDec = 9'd2; // Inc word then dec word.
	localparam logic [uopIdxW-1:0] flowAluReg = 9'd4; // Add word then sub word.
	localparam logic [uopIdxW-1:0] flowXorN   = 9'd6;
	localparam logic [uopIdxW-1:0] flowJrNz   = 9'd7;
	localparam logic [uopIdxW-1:0] flowJpNn   = 9'd9;
	localparam logic [uopIdxW-1:0] flowHalt   = 9'd11;
	localparam logic [uopIdxW-1:0] flowTrap   = 9'd12;

	// Register order follows the opcode fields with A in the last slot.
	localparam logic [regIdxW-1:0] regIdxOp = 3'd6; // Free slot that takes dst from the opcode.
	localparam logic [regIdxW-1:0] regIdxA  = 3'd7;

	localparam logic [2:0] aluPass = 3'd0;
	localparam logic [2:0] aluInc  = 3'd1;
	localparam logic [2:0] aluDec  = 3'd2;
	localparam logic [2:0] aluAdd  = 3'd3;
	localparam logic [2:0] aluSub  = 3'd4;
	localparam logic [2:0] aluXor  = 3'd5;

	localparam logic formAlu  = 1'b0;
	localparam logic formCtrl = 1'b1;

	localparam logic [1:0] ctrlJr   = 2'd0;
	localparam logic [1:0] ctrlJp   = 2'd1;
	localparam logic [1:0] ctrlHalt = 2'd2;
	localparam logic [1:0] ctrlTrap = 2'd3;

	localparam logic condAlways = 1'b0;
	localparam logic condNz     = 1'b1;

	localparam logic [2:0] stIdle    = 3'd0;
	localparam logic [2:0] stFetch   = 3'd1;
	localparam logic [2:0] stDecode  = 3'd2;
	localparam logic [2:0] stExec    = 3'd3;
	localparam logic [2:0] stImmLow  = 3'd4;
	localparam logic [2:0] stImmHigh = 3'd5;

	typedef union packed {
		struct packed {
			logic               form;
			logic [2:0]         aluOp;
			logic [regIdxW-1:0] dst;
			logic               srcImm;
			logic               wrEn;
			logic               fetchImm;
			logic               last;
			logic [4:0]         rsvd;
		} alu;
		struct packed {
			logic               form;
			logic [1:0]         kind;
			logic               cond;
			logic               fetchHigh;
			logic               last;
			logic [9:0]         rsvd;
		} ctrl;
	} uopWord_u;

endpackage

/* hw/dzcpuProgMem.sv */
module dzcpuProgMem
(
	input  logic       iClock,
	input  logic       wrEn,
	input  logic [7:0] wrAddr,
	input  logic [7:0] wrData,
	input  logic [7:0] rdAddr,
	output logic [7:0] rdData
);

	logic [7:0] mem [256];

	always_ff @(posedge iClock)
	begin
		if (wrEn)
		begin
			mem[wrAddr] <= wrData;
		end
		rdData <= mem[rdAddr]; // Data shows up one cycle after the address.
	end

endmodule

/* ucode/dzcpuUcodeLut.sv */
module dzcpuUcodeLut
(
	input  logic [7:0]                   mop,
	output logic [dzcpuPkg::uopIdxW-1:0] uopFlowIdx
);

	import dzcpuPkg::*;

	always_comb
	begin
		case (mop)
			opNop:   uopFlowIdx = flowNop;
			opLdBn:  uopFlowIdx = flowLdRn;
			opLdCn:  uopFlowIdx = flowLdRn;
			opLdAn:  uopFlowIdx = flowLdRn;
			opIncB:  uopFlowIdx = flowIncDec;
			opIncC:  uopFlowIdx = flowIncDec;
			opIncA:  uopFlowIdx = flowIncDec;
			opDecB:  uopFlowIdx = flowIncDec + 1'b1;
			opDecC:  uopFlowIdx = flowIncDec + 1'b1;
			opDecA:  uopFlowIdx = flowIncDec + 1'b1;
			opAddAB: uopFlowIdx = flowAluReg;
			opSubAB: uopFlowIdx = flowAluReg + 1'b1;
			opXorN:  uopFlowIdx = flowXorN;
			opJrNz:  uopFlowIdx = flowJrNz;
			opJpNn:  uopFlowIdx = flowJpNn;
			opHalt:  uopFlowIdx = flowHalt;
			default: uopFlowIdx = flowTrap; // Not implemented.
		endcase
	end

endmodule

/* ucode/dzcpuUcodeRom.sv */
module dzcpuUcodeRom
(
	input  logic [dzcpuPkg::uopIdxW-1:0] uopIdx,
	output dzcpuPkg::uopWord_u           uop
);

	import dzcpuPkg::*;

	function automatic uopWord_u aluWord(input logic [2:0] op, input logic [regIdxW-1:0] dst,
		input logic srcImm, input logic wrEn, input logic fetchImm, input logic last);
		uopWord_u w;
		w = '0;
		w.alu.form = formAlu;
		w.alu.aluOp = op;
		w.alu.dst = dst;
		w.alu.srcImm = srcImm;
		w.alu.wrEn = wrEn;
		w.alu.fetchImm = fetchImm;
		w.alu.last = last;
		return w;
	endfunction

	function automatic uopWord_u ctrlWord(input logic [1:0] kind, input logic cond,
		input logic fetchHigh, input logic last);
		uopWord_u w;
		w = '0;
		w.ctrl.form = formCtrl;
		w.ctrl.kind = kind;
		w.ctrl.cond = cond;
		w.ctrl.fetchHigh = fetchHigh;
		w.ctrl.last = last;
		return w;
	endfunction

	always_comb
	begin
		case (uopIdx)
			flowNop:            uop = aluWord(aluPass, regIdxA, 1'b0, 1'b0, 1'b0, 1'b1);
			flowLdRn:           uop = aluWord(aluPass, regIdxOp, 1'b1, 1'b1, 1'b1, 1'b1);
			flowIncDec:         uop = aluWord(aluInc, regIdxOp, 1'b0, 1'b1, 1'b0, 1'b1);
			flowIncDec + 1'b1:  uop = aluWord(aluDec, regIdxOp, 1'b0, 1'b1, 1'b0, 1'b1);
			flowAluReg:         uop = aluWord(aluAdd, regIdxA, 1'b0, 1'b1, 1'b0, 1'b1); // ADD A,B
			flowAluReg + 1'b1:  uop = aluWord(aluSub, regIdxA, 1'b0, 1'b1, 1'b0, 1'b1); // SUB A,B
			flowXorN:           uop = aluWord(aluXor, regIdxA, 1'b1, 1'b1, 1'b1, 1'b1);
			flowJrNz:           uop = aluWord(aluPass, regIdxA, 1'b1, 1'b0, 1'b1, 1'b0); // Offset.
			flowJrNz + 1'b1:    uop = ctrlWord(ctrlJr, condNz, 1'b0, 1'b1);
			flowJpNn:           uop = aluWord(aluPass, regIdxA, 1'b1, 1'b0, 1'b1, 1'b0); // Low byte.
			flowJpNn + 1'b1:    uop = ctrlWord(ctrlJp, condAlways, 1'b1, 1'b1);
			flowHalt:           uop = ctrlWord(ctrlHalt, condAlways, 1'b0, 1'b1);
			flowTrap:           uop = ctrlWord(ctrlTrap, condAlways, 1'b0, 1'b1);
			default:            uop = ctrlWord(ctrlTrap, condAlways, 1'b0, 1'b1);
		endcase
	end

endmodule

/* ucode/dzcpuSequencer.sv */
module dzcpuSequencer
(
	input  logic                         iClock,
	input  logic                         rstN,
	input  logic                         start,
	input  logic [7:0]                   memData,
	input  logic [7:0]                   pc,
	input  logic                         flagZ,
	output logic [7:0]                   mop,
	input  logic [dzcpuPkg::uopIdxW-1:0] uopFlowIdx,
	output logic [dzcpuPkg::uopIdxW-1:0] uopIdx,
	input  dzcpuPkg::uopWord_u           uop,
	output logic                         uopValid,
	output dzcpuPkg::uopWord_u           uopOut,
	output logic [7:0]                   opcode,
	output logic [7:0]                   imm,
	output logic                         pcInc,
	output logic                         pcLoad,
	output logic [7:0]                   pcLoadValue,
	output logic                         halted,
	output logic                         illegal
);

	import dzcpuPkg::*;

	logic [2:0]         state;
	logic               dataPhase;
	logic [uopIdxW-1:0] upc;
	logic [7:0]         opcodeQ;
	logic [7:0]         immQ;
	logic               isCtrl;
	logic               uopLast;
	logic               uopFetch;
	logic               issue;
	logic               isJump;

	assign isCtrl = uop.ctrl.form == formCtrl;
	assign uopLast = isCtrl ? uop.ctrl.last : uop.alu.last;
	assign uopFetch = isCtrl ? uop.ctrl.fetchHigh : uop.alu.fetchImm;

	// A fetching micro-op issues only after its byte has arrived.
	assign issue = (state == stExec && !uopFetch) || state == stImmHigh;
	assign isJump = isCtrl && (uop.ctrl.kind == ctrlJr || uop.ctrl.kind == ctrlJp);

	assign uopValid = issue;
	assign uopOut = uop;
	assign uopIdx = upc;
	assign mop = opcodeQ;
	assign opcode = opcodeQ;
	assign imm = immQ;

	assign pcInc = (state == stFetch && !dataPhase) || (state == stExec && uopFetch);
	assign pcLoad = issue && isJump && (uop.ctrl.cond == condAlways || !flagZ);
	assign pcLoadValue = (uop.ctrl.kind == ctrlJp) ? immQ : pc + immQ; // Offset wraps in 8 bits.

	always_ff @(posedge iClock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			dataPhase <= 1'b0;
			upc <= '0;
			halted <= 1'b1;
			illegal <= 1'b0;
		end
		else if (start)
		begin
			state <= stFetch;
			dataPhase <= 1'b0;
			halted <= 1'b0;
			illegal <= 1'b0;
		end
		else
		begin
			case (state)
				stFetch:
				begin
					dataPhase <= !dataPhase;
					if (dataPhase)
					begin
						state <= stDecode;
					end
				end
				stDecode:
				begin
					upc <= uopFlowIdx;
					state <= stExec;
				end
				stExec:
				begin
					if (uopFetch)
					begin
						state <= stImmLow;
					end
				end
				stImmLow: state <= stImmHigh;
				default: ;
			endcase

			if (issue)
			begin
				if (!uopLast)
				begin
					upc <= upc + 1'b1;
					state <= stExec;
				end
				else if (isCtrl && (uop.ctrl.kind == ctrlHalt || uop.ctrl.kind == ctrlTrap))
				begin
					halted <= 1'b1;
					illegal <= uop.ctrl.kind == ctrlTrap;
					state <= stIdle;
				end
				else
				begin
					state <= stFetch;
				end
			end
		end
	end

	always_ff @(posedge iClock)
	begin
		if (state == stFetch && dataPhase)
		begin
			opcodeQ <= memData;
		end
		if (state == stImmLow && !isCtrl)
		begin
			immQ <= memData; // High byte of JP nn is dropped.
		end
	end

endmodule

/* hw/dzcpuDatapath.sv */
module dzcpuDatapath
(
	input  logic                         iClock,
	input  logic                         rstN,
	input  logic                         start,
	input  logic                         uopValid,
	input  dzcpuPkg::uopWord_u           uop,
	input  logic [7:0]                   opcode,
	input  logic [7:0]                   imm,
	input  logic                         pcInc,
	input  logic                         pcLoad,
	input  logic [7:0]                   pcLoadValue,
	output logic [7:0]                   pc,
	output logic                         regWrValid,
	output logic [dzcpuPkg::regIdxW-1:0] regWrIdx,
	output logic [7:0]                   regWrData,
	output logic                         flagZ,
	output logic                         flagC
);

	import dzcpuPkg::*;

	logic [7:0]         regs [8];
	logic [regIdxW-1:0] dstIdx;
	logic [7:0]         opA;
	logic [7:0]         opB;
	logic [8:0]         sum;
	logic [8:0]         diff;
	logic [7:0]         result;
	logic               updZ;
	logic               updC;
	logic               newC;
	logic               isAlu;
	logic               doWrite;

	assign isAlu = uopValid && uop.alu.form == formAlu;
	assign doWrite = isAlu && uop.alu.wrEn;

	assign dstIdx = (uop.alu.dst == regIdxOp) ? opcode[5:3] : uop.alu.dst;
	assign opA = regs[dstIdx];
	assign opB = uop.alu.srcImm ? imm : regs[opcode[2:0]];

	assign sum = {1'b0, opA} + {1'b0, opB};
	assign diff = {1'b0, opA} - {1'b0, opB}; // Bit 8 is the borrow.

	always_comb
	begin
		result = opB;
		updZ = 1'b1;
		updC = 1'b0;
		newC = 1'b0;
		case (uop.alu.aluOp)
			aluInc: result = opA + 8'd1;
			aluDec: result = opA - 8'd1;
			aluAdd:
			begin
				result = sum[7:0];
				updC = 1'b1;
				newC = sum[8];
			end
			aluSub:
			begin
				result = diff[7:0];
				updC = 1'b1;
				newC = diff[8];
			end
			aluXor:
			begin
				result = opA ^ opB;
				updC = 1'b1;
			end
			default: updZ = 1'b0; // Pass leaves the flags alone.
		endcase
	end

	always_ff @(posedge iClock or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= 8'd0;
			flagZ <= 1'b0;
			flagC <= 1'b0;
			regWrValid <= 1'b0;
		end
		else
		begin
			regWrValid <= doWrite;
			if (start)
			begin
				pc <= 8'd0;
				flagZ <= 1'b0;
				flagC <= 1'b0;
			end
			else
			begin
				if (pcLoad)
				begin
					pc <= pcLoadValue;
				end
				else if (pcInc)
				begin
					pc <= pc + 8'd1;
				end
				if (isAlu && updZ)
				begin
					flagZ <= result == 8'd0;
				end
				if (isAlu && updC)
				begin
					flagC <= newC;
				end
			end
		end
	end

	always_ff @(posedge iClock)
	begin
		if (doWrite)
		begin
			regs[dstIdx] <= result;
			regWrIdx <= dstIdx;
			regWrData <= result;
		end
	end

endmodule

/* hw/dzcpuCore.sv */
module dzcpuCore
(
	input  logic                         iClock,
	input  logic                         rstN,
	input  logic                         start,
	input  logic                         progWrEn,
	input  logic [7:0]                   progWrAddr,
	input  logic [7:0]                   progWrData,
	output logic                         regWrValid,
	output logic [dzcpuPkg::regIdxW-1:0] regWrIdx,
	output logic [7:0]                   regWrData,
	output logic                         flagZ,
	output logic                         flagC,
	output logic                         halted,
	output logic                         illegal
);

	import dzcpuPkg::*;

	logic [7:0]         pc;
	logic [7:0]         memData;
	logic [7:0]         mop;
	logic [uopIdxW-1:0] uopFlowIdx;
	logic [uopIdxW-1:0] uopIdx;
	uopWord_u           romUop;
	uopWord_u           issuedUop;
	logic               uopValid;
	logic [7:0]         opcode;
	logic [7:0]         imm;
	logic               pcInc;
	logic               pcLoad;
	logic [7:0]         pcLoadValue;

	dzcpuProgMem progMem_i
	(
		.iClock (iClock),
		.wrEn   (progWrEn),
		.wrAddr (progWrAddr),
		.wrData (progWrData),
		.rdAddr (pc), // Memory address is always the PC.
		.rdData (memData)
	);

	dzcpuSequencer sequencer_i
	(
		.iClock      (iClock),
		.rstN        (rstN),
		.start       (start),
		.memData     (memData),
		.pc          (pc),
		.flagZ       (flagZ),
		.mop         (mop),
		.uopFlowIdx  (uopFlowIdx),
		.uopIdx      (uopIdx),
		.uop         (romUop),
		.uopValid    (uopValid),
		.uopOut      (issuedUop),
		.opcode      (opcode),
		.imm         (imm),
		.pcInc       (pcInc),
		.pcLoad      (pcLoad),
		.pcLoadValue (pcLoadValue),
		.halted      (halted),
		.illegal     (illegal)
	);

	dzcpuUcodeLut ucodeLut_i
	(
		.mop        (mop),
		.uopFlowIdx (uopFlowIdx)
	);

	dzcpuUcodeRom ucodeRom_i
	(
		.uopIdx (uopIdx),
		.uop    (romUop)
	);

	dzcpuDatapath datapath_i
	(
		.iClock      (iClock),
		.rstN        (rstN),
		.start       (start),
		.uopValid    (uopValid),
		.uop         (issuedUop),
		.opcode      (opcode),
		.imm         (imm),
		.pcInc       (pcInc),
		.pcLoad      (pcLoad),
		.pcLoadValue (pcLoadValue),
		.pc          (pc),
		.regWrValid  (regWrValid),
		.regWrIdx    (regWrIdx),
		.regWrData   (regWrData),
		.flagZ       (flagZ),
		.flagC       (flagC)
	);

endmodule

/* tb/dzcpuTb.sv */
module dzcpuTb;

	timeunit 1ns;
	timeprecision 1ps;

	import dzcpuPkg::*;

	localparam int waitLimit = 4000;
	localparam int modelStepLimit = 4000;

	logic       clk;
	logic       rstN;
	logic       start;
	logic       progWrEn;
	logic [7:0] progWrAddr;
	logic [7:0] progWrData;
	logic       regWrValid;
	logic [2:0] regWrIdx;
	logic [7:0] regWrData;
	logic       flagZ;
	logic       flagC;
	logic       halted;
	logic       illegal;

	logic [7:0]  prog [256];
	int          progLen;
	logic [10:0] expWrites [$]; // {index, data}.
	logic [10:0] gotWrites [$];
	logic        expZ;
	logic        expC;
	logic        expIllegal;
	logic        collect;
	int          errCount;
	int          checkCount;
	int          testCount;

	logic [7:0] ldOp [3] = '{opLdAn, opLdBn, opLdCn};
	logic [7:0] incOp [3] = '{opIncA, opIncB, opIncC};
	logic [7:0] decOp [3] = '{opDecA, opDecB, opDecC};
	logic [7:0] wrapVals [4] = '{8'hFF, 8'h00, 8'h01, 8'hFE};

	dzcpuCore dut_i
	(
		.iClock     (clk),
		.rstN       (rstN),
		.start      (start),
		.progWrEn   (progWrEn),
		.progWrAddr (progWrAddr),
		.progWrData (progWrData),
		.regWrValid (regWrValid),
		.regWrIdx   (regWrIdx),
		.regWrData  (regWrData),
		.flagZ      (flagZ),
		.flagC      (flagC),
		.halted     (halted),
		.illegal    (illegal)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(negedge clk)
	begin
		if (collect && regWrValid)
		begin
			gotWrites.push_back({regWrIdx, regWrData});
		end
	end

	task automatic compareHex(input string name, input logic [15:0] got, input logic [15:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			$display("ERR %s got 0x%0h exp 0x%0h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic requireTrue(input logic cond, input string what);
		checkCount++;
		assert (cond === 1'b1)
		else
		begin
			$display("%s", what);
			errCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errs0, input int checks0);
		testCount++;
		$display("%-16s %0d checks, %0d errors", name, checkCount - checks0, errCount - errs0);
	endtask

	task automatic emit(input logic [7:0] b);
		prog[progLen] = b;
		progLen++;
	endtask

	task automatic emitPair(input logic [7:0] op, input logic [7:0] n);
		emit(op);
		emit(n);
	endtask

	// Instruction-level model of the opcode rules that runs prog from address 0.
	task automatic modelRun();
		logic [7:0] r [8];
		logic [7:0] mpc;
		logic [7:0] op;
		logic [7:0] n;
		logic [8:0] t;
		logic       z;
		logic       c;
		logic       done;
		int         steps;
		expWrites.delete();
		for (steps = 0; steps < 8; steps++)
		begin
			r[steps] = 8'd0;
		end
		mpc = 8'd0;
		z = 1'b0;
		c = 1'b0;
		done = 1'b0;
		expIllegal = 1'b0;
		steps = 0;
		while (!done && steps < modelStepLimit)
		begin
			op = prog[mpc];
			n = prog[mpc + 8'd1];
			steps++;
			case (op)
				opNop: mpc = mpc + 8'd1;
				opLdAn, opLdBn, opLdCn:
				begin
					r[op[5:3]] = n;
					expWrites.push_back({op[5:3], n});
					mpc = mpc + 8'd2;
				end
				opIncA, opIncB, opIncC, opDecA, opDecB, opDecC:
				begin
					r[op[5:3]] = op[0] ? r[op[5:3]] - 8'd1 : r[op[5:3]] + 8'd1; // Bit 0 set is DEC.
					z = r[op[5:3]] == 8'd0;
					expWrites.push_back({op[5:3], r[op[5:3]]});
					mpc = mpc + 8'd1;
				end
				opAddAB, opSubAB:
				begin
					if (op == opAddAB)
					begin
						t = {1'b0, r[7]} + {1'b0, r[0]};
						c = t[8];
					end
					else
					begin
						t = {1'b0, r[7] - r[0]};
						c = r[7] < r[0]; // Borrow.
					end
					r[7] = t[7:0];
					z = r[7] == 8'd0;
					expWrites.push_back({3'd7, r[7]});
					mpc = mpc + 8'd1;
				end
				opXorN:
				begin
					r[7] = r[7] ^ n;
					z = r[7] == 8'd0;
					c = 1'b0;
					expWrites.push_back({3'd7, r[7]});
					mpc = mpc + 8'd2;
				end
				opJrNz:
				begin
					mpc = mpc + 8'd2;
					if (!z)
					begin
						mpc = mpc + n; // Signed offset wraps in 8 bits.
					end
				end
				opJpNn: mpc = n;
				opHalt: done = 1'b1;
				default:
				begin
					done = 1'b1;
					expIllegal = 1'b1;
				end
			endcase
		end
		expZ = z;
		expC = c;
		requireTrue(done, "reference model never reached a halt");
	endtask

	task automatic runProgram();
		int i;
		int n;
		for (i = 0; i < progLen; i++)
		begin
			@(posedge clk);
			#2;
			progWrEn = 1'b1;
			progWrAddr = 8'(i);
			progWrData = prog[i];
		end
		@(posedge clk);
		#2;
		progWrEn = 1'b0;
		modelRun();
		gotWrites.delete();
		collect = 1'b1;
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		n = 0;
		while (halted !== 1'b1 && n < waitLimit)
		begin
			@(negedge clk);
			n++;
		end
		requireTrue(halted, "core did not halt before the timeout");
		repeat (4) @(negedge clk); // Quiet window for late writes.
		collect = 1'b0;
		compareHex("regWrValid count", gotWrites.size(), expWrites.size());
		for (i = 0; i < gotWrites.size() && i < expWrites.size(); i++)
		begin
			compareHex("regWrIdx", gotWrites[i][10:8], expWrites[i][10:8]);
			compareHex("regWrData", gotWrites[i][7:0], expWrites[i][7:0]);
		end
		compareHex("flagZ", flagZ, expZ);
		compareHex("flagC", flagC, expC);
		compareHex("illegal", illegal, expIllegal);
	endtask

	task automatic checkResetState();
		int e0;
		int c0;
		e0 = errCount;
		c0 = checkCount;
		compareHex("halted", halted, 1'b1);
		compareHex("illegal", illegal, 1'b0);
		compareHex("regWrValid", regWrValid, 1'b0);
		reportTest("reset state", e0, c0);
	endtask

	task automatic loadImmediates();
		int e0;
		int c0;
		e0 = errCount;
		c0 = checkCount;
		progLen = 0;
		emitPair(opLdAn, 8'($urandom()));
		emitPair(opLdBn, 8'($urandom()));
		emitPair(opLdCn, 8'h00); // A zero load must not set Z.
		emit(opHalt);
		runProgram();
		compareHex("regWrValid count", gotWrites.size(), 3);
		compareHex("flagZ", flagZ, 1'b0);
		compareHex("flagC", flagC, 1'b0);
		reportTest("load immediate", e0, c0);
	endtask

	task automatic incDecWrap();
		int e0;
		int c0;
		int r;
		int v;
		int d;
		e0 = errCount;
		c0 = checkCount;
		for (r = 0; r < 3; r++)
		begin
			for (v = 0; v < 4; v++)
			begin
				for (d = 0; d < 2; d++)
				begin
					progLen = 0;
					emitPair(opLdAn, 8'hF0);
					emitPair(opLdBn, 8'h20);
					emit(opAddAB); // Leaves C set.
					emitPair(ldOp[r], wrapVals[v]);
					emit(d ? decOp[r] : incOp[r]);
					emit(opHalt);
					runProgram();
					compareHex("flagC", flagC, 1'b1);
				end
			end
		end
		reportTest("inc dec wrap", e0, c0);
	endtask

	task automatic aluArithmetic();
		int e0;
		int c0;
		int k;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] n;
		e0 = errCount;
		c0 = checkCount;
		for (k = 0; k < 6; k++)
		begin
			a = 8'($urandom());
			b = 8'($urandom());
			n = 8'($urandom());
			if (k == 0)
			begin
				a = 8'hF0; // Sum wraps to zero with carry.
				b = 8'h10;
			end
			if (k == 1)
			begin
				b = a;
				n = a + a;
			end
			progLen = 0;
			emitPair(opLdAn, a);
			emitPair(opLdBn, b);
			emit(opAddAB);
			emit(opHalt);
			runProgram();
			progLen = 0;
			emitPair(opLdAn, a);
			emitPair(opLdBn, b);
			emit(opSubAB);
			emit(opHalt);
			runProgram();
			progLen = 0;
			emitPair(opLdAn, a);
			emitPair(opLdBn, b);
			emit(opAddAB);
			emitPair(opXorN, n);
			emit(opHalt);
			runProgram();
			compareHex("flagC", flagC, 1'b0);
		end
		reportTest("alu ops", e0, c0);
	endtask

	task automatic countdownAndJump();
		int e0;
		int c0;
		int k;
		logic [7:0] count;
		e0 = errCount;
		c0 = checkCount;
		for (k = 0; k < 2; k++)
		begin
			count = k ? 8'($urandom_range(1, 16)) : 8'd3;
			progLen = 0;
			emitPair(opLdBn, count);
			emit(opDecB);
			emitPair(opJrNz, 8'hFD); // Back to the DEC at address 2.
			emit(opHalt);
			runProgram();
			compareHex("regWrValid count", gotWrites.size(), count + 1);
			if (gotWrites.size() > 0)
			begin
				compareHex("regWrIdx", gotWrites[gotWrites.size() - 1][10:8], 3'd0);
				compareHex("regWrData", gotWrites[gotWrites.size() - 1][7:0], 8'd0);
			end
		end
		progLen = 0;
		emit(opJpNn);
		emitPair(8'h05, 8'h12); // High byte is ignored.
		emitPair(opLdAn, 8'h55);
		emitPair(opLdCn, 8'h77);
		emit(opHalt);
		runProgram();
		compareHex("regWrValid count", gotWrites.size(), 1);
		if (gotWrites.size() > 0)
		begin
			compareHex("regWrIdx", gotWrites[0][10:8], 3'd1);
			compareHex("regWrData", gotWrites[0][7:0], 8'h77);
		end
		reportTest("branches", e0, c0);
	endtask

	task automatic illegalOpcode();
		int e0;
		int c0;
		e0 = errCount;
		c0 = checkCount;
		progLen = 0;
		emitPair(opLdAn, 8'h42);
		emit(8'hD3); // Not implemented.
		emitPair(opLdBn, 8'h11);
		emit(opHalt);
		runProgram();
		compareHex("regWrValid count", gotWrites.size(), 1);
		compareHex("illegal", illegal, 1'b1);
		compareHex("halted", halted, 1'b1);
		progLen = 0;
		emitPair(opLdBn, 8'h24);
		emit(opHalt);
		runProgram();
		compareHex("illegal", illegal, 1'b0);
		reportTest("illegal opcode", e0, c0);
	endtask

	initial
	begin
		void'($urandom(32'h0f652680));
		rstN = 1'b0;
		start = 1'b0;
		progWrEn = 1'b0;
		progWrAddr = 8'd0;
		progWrData = 8'd0;
		collect = 1'b0;
		errCount = 0;
		checkCount = 0;
		testCount = 0;
		progLen = 0;
		repeat (3) @(posedge clk);
		#2;
		rstN = 1'b1;
		@(negedge clk);
		checkResetState();
		loadImmediates();
		incDecWrap();
		aluArithmetic();
		countdownAndJump();
		illegalOpcode();
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
		if (errCount == 0)
		begin
			$display("sim passed");
		end
		else
		begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* sources.f */
common/dzcpuPkg.sv
hw/dzcpuProgMem.sv
ucode/dzcpuUcodeLut.sv
ucode/dzcpuUcodeRom.sv
ucode/dzcpuSequencer.sv
hw/dzcpuDatapath.sv
hw/dzcpuCore.sv
tb/dzcpuTb.sv

/* Bender.yml */
package:
  name: dzcpu

sources:
  - common/dzcpuPkg.sv
  - hw/dzcpuProgMem.sv
  - ucode/dzcpuUcodeLut.sv
  - ucode/dzcpuUcodeRom.sv
  - ucode/dzcpuSequencer.sv
  - hw/dzcpuDatapath.sv
  - hw/dzcpuCore.sv
  - target: test
    files:
      - tb/dzcpuTb.sv
